/* bus_return.sv */
`include "main_cfg.svh"

module bus_return import main_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`MAIN_SLOTS-1:0] done,
    input  bus_data_t              slot_rdata [`MAIN_SLOTS],
    input  logic                   io_done,
    input  bus_data_t              io_rdata,
    input  logic                   err_sel,
    input  logic                   req,
    output logic                   ack,
    output bus_rsp_t               rsp
);

    logic     err_q;   // Error path completes one cycle after its strobe
    logic     cmpl;
    bus_rsp_t next_rsp;

    assign cmpl = (|done) || io_done || err_q;

    // Only one source completes per access
    always_comb begin
        next_rsp.rdata = 16'hffff;
        next_rsp.berr  = 1'b0;
        if (err_q) begin
            next_rsp.berr = 1'b1;
        end else if (io_done) begin
            next_rsp.rdata = io_rdata;
        end else begin
            for (int i = 0; i < `MAIN_SLOTS; i++) begin
                if (done[i]) next_rsp.rdata = slot_rdata[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            err_q     <= 1'b0;
            ack       <= 1'b0;
            rsp.rdata <= 16'hffff;
            rsp.berr  <= 1'b0;
        end else begin
            err_q <= err_sel;
            if (cmpl) begin
                rsp <= next_rsp;
                ack <= 1'b1;
            end else if (ack && !req) begin
                ack <= 1'b0;   // rsp stays put until the next completion
            end
        end
    end

endmodule

/* cab_io.sv */
module cab_io import main_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       sel,
    input  bus_req_t   io_req,
    input  cab_byte_t  joystick1,
    input  cab_byte_t  joystick2,
    input  cab_byte_t  dipsw_a,
    input  cab_byte_t  dipsw_b,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    output logic       io_done,
    output bus_data_t  io_rdata,
    output cab_byte_t  snd_latch,
    output logic       flip
);

    cab_byte_t ctrl;
    cab_byte_t cab_dout;
    logic      lo_wr;

    // Board wiring scrambles the joystick lines
    function automatic cab_byte_t sort_joy(input cab_byte_t j);
        return {j[1], j[0], j[3], j[2], j[7], j[5], j[4], j[6]};
    endfunction

    assign flip  = ctrl[7];
    assign lo_wr = io_req.we && io_req.be[0];

    always_comb begin
        cab_dout = 8'hff;
        case (io_req.addr[13:12])
            2'd0: begin   // Latch and control registers
                if (io_req.addr[2:1] == 2'd0) cab_dout = snd_latch;
                else if (io_req.addr[2:1] == 2'd1) cab_dout = ctrl;
            end
            2'd1: begin
                case (io_req.addr[2:1])
                    2'd0: cab_dout = {2'b11, start_button, service, 1'b1, coin_input};
                    2'd1: cab_dout = sort_joy(joystick1);
                    2'd3: cab_dout = sort_joy(joystick2);
                    default: cab_dout = 8'hff;
                endcase
            end
            2'd2: cab_dout = io_req.addr[1] ? dipsw_b : dipsw_a;
            default: cab_dout = 8'hff;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            io_done   <= 1'b0;
            io_rdata  <= 16'hffff;
            snd_latch <= 8'h00;
            ctrl      <= 8'h00;
        end else begin
            io_done <= sel;
            if (sel) begin
                io_rdata <= io_req.we ? 16'hffff : {8'hff, cab_dout};   // Writes read back ffff
                if (lo_wr && io_req.addr[13:12] == 2'd0) begin
                    if (io_req.addr[2:1] == 2'd0) snd_latch <= io_req.wdata[7:0];
                    if (io_req.addr[2:1] == 2'd1) ctrl      <= io_req.wdata[7:0];
                end
            end
        end
    end

endmodule

/* main_board.sv */
`include "main_cfg.svh"

module main_board import main_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    // Master port
    input  logic       req,
    input  bus_req_t   req_data,
    output logic       ack,
    output bus_rsp_t   rsp,
    // Cabinet
    input  cab_byte_t  joystick1,
    input  cab_byte_t  joystick2,
    input  cab_byte_t  dipsw_a,
    input  cab_byte_t  dipsw_b,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    // Video timing and interrupt
    input  logic [8:0] vdump,
    input  logic       hstart,
    input  logic       irq_ack,
    output logic       irq_n,
    // Sound and video control
    output cab_byte_t  snd_latch,
    output logic       flip
);

    bus_req_t               cur_req;
    logic [`MAIN_SLOTS-1:0] slot_sel;
    logic [`MAIN_SLOTS-1:0] slot_done;
    bus_data_t              slot_rdata [`MAIN_SLOTS];
    logic                   io_sel;
    logic                   io_done;
    bus_data_t              io_rdata;
    logic                   err_sel;

    main_decoder main_decoder_inst (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .cur_req  (cur_req),
        .slot_sel (slot_sel),
        .io_sel   (io_sel),
        .err_sel  (err_sel)
    );

    // vram, obj, pal and wram in slot order
    for (genvar i = 0; i < `MAIN_SLOTS; i++) begin : g_slot
        ram_slot ram_slot_inst (
            .clk      (clk),
            .rst      (rst),
            .sel      (slot_sel[i]),
            .slot_req (cur_req),
            .done     (slot_done[i]),
            .rdata    (slot_rdata[i])
        );
    end

    cab_io cab_io_inst (
        .clk          (clk),
        .rst          (rst),
        .sel          (io_sel),
        .io_req       (cur_req),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .io_done      (io_done),
        .io_rdata     (io_rdata),
        .snd_latch    (snd_latch),
        .flip         (flip)
    );

    bus_return bus_return_inst (
        .clk        (clk),
        .rst        (rst),
        .done       (slot_done),
        .slot_rdata (slot_rdata),
        .io_done    (io_done),
        .io_rdata   (io_rdata),
        .err_sel    (err_sel),
        .req        (req),
        .ack        (ack),
        .rsp        (rsp)
    );

    vblank_irq vblank_irq_inst (
        .clk     (clk),
        .rst     (rst),
        .vdump   (vdump),
        .hstart  (hstart),
        .irq_ack (irq_ack),
        .irq_n   (irq_n)
    );

endmodule

/* main_cfg.svh */
`ifndef MAIN_CFG_SVH
`define MAIN_CFG_SVH

// RAM slots behind the decoder, in the order vram, obj, pal, wram
`define MAIN_SLOTS      4

// Word address bits kept per slot, the rest of the region mirrors
`define MAIN_SLOT_AW    10

// Extra cycles a RAM slot spends before it completes
`define MAIN_WAIT       2

// Video line whose hstart edge raises the VBLANK request
`define MAIN_VBL_LINE   9'd223

// Byte address bits 23 to 16 of each mapped region
`define MAIN_RGN_VRAM   8'h40
`define MAIN_RGN_OBJ    8'h44
`define MAIN_RGN_PAL    8'h84
`define MAIN_RGN_WRAM   8'hc7
`define MAIN_RGN_IO     8'hc4

`endif

/* main_decoder.sv */
`include "main_cfg.svh"

module main_decoder import main_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  bus_req_t               req_data,
    input  logic                   ack,
    output bus_req_t               cur_req,
    output logic [`MAIN_SLOTS-1:0] slot_sel,
    output logic                   io_sel,
    output logic                   err_sel
);

    dec_state_e state;
    region_e    rgn;
    logic       ack_q;

    function automatic region_e decode(input logic [7:0] hi);
        region_e r;
        case (hi)
            `MAIN_RGN_VRAM: r = reg_vram;
            `MAIN_RGN_OBJ:  r = reg_obj;
            `MAIN_RGN_PAL:  r = reg_pal;
            `MAIN_RGN_WRAM: r = reg_wram;
            `MAIN_RGN_IO:   r = reg_io;
            default:        r = reg_none;
        endcase
        return r;
    endfunction

    assign rgn = decode(cur_req.addr[23:16]);

    // Request is latched once per four-phase cycle
    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            cur_req <= req_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            slot_sel <= '0;
            io_sel   <= 1'b0;
            err_sel  <= 1'b0;
            ack_q    <= 1'b0;
        end else begin
            slot_sel <= '0;   // Selects are single-cycle strobes
            io_sel   <= 1'b0;
            err_sel  <= 1'b0;
            ack_q    <= ack;
            case (state)
                st_idle: begin
                    if (req) state <= st_busy;
                end
                st_busy: begin
                    case (rgn)
                        reg_vram, reg_obj, reg_pal, reg_wram: slot_sel[rgn[1:0]] <= 1'b1;
                        reg_io:  io_sel  <= 1'b1;
                        default: err_sel <= 1'b1;
                    endcase
                    state <= st_wait_drop;
                end
                st_wait_drop: begin
                    // Ack only falls once req was seen low, so its falling
                    // edge closes the cycle even if the master raises req again
                    if (ack_q && !ack) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* main_pkg.sv */
package main_pkg;

    // Word address, bit 0 of the byte address is never on the bus
    typedef logic [23:1] bus_addr_t;
    typedef logic [15:0] bus_data_t;
    typedef logic [1:0]  byte_en_t;   // Bit 1 upper lane, bit 0 lower lane
    typedef logic [7:0]  cab_byte_t;

    // Slot targets share their value with the slot index
    typedef enum logic [2:0] {
        reg_vram = 3'd0,
        reg_obj  = 3'd1,
        reg_pal  = 3'd2,
        reg_wram = 3'd3,
        reg_io   = 3'd4,
        reg_none = 3'd5
    } region_e;

    typedef struct packed {
        bus_addr_t addr;
        bus_data_t wdata;
        logic      we;    // High for a write
        byte_en_t  be;
    } bus_req_t;

    typedef struct packed {
        bus_data_t rdata;
        logic      berr;  // Unmapped address
    } bus_rsp_t;

    // Bus cycle of the slave front end
    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_wait_drop
    } dec_state_e;

endpackage

/* project.f */
+incdir+.
main_pkg.sv
main_decoder.sv
ram_slot.sv
cab_io.sv
vblank_irq.sv
bus_return.sv
main_board.sv
tb_main_board.sv

/* ram_slot.sv */
`include "main_cfg.svh"

module ram_slot import main_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      sel,
    input  bus_req_t  slot_req,
    output logic      done,
    output bus_data_t rdata
);

    localparam int CW = $clog2(`MAIN_WAIT + 2);

    bus_data_t                mem [2**`MAIN_SLOT_AW];
    logic [`MAIN_SLOT_AW-1:0] idx;
    logic [CW-1:0]            cnt;
    logic                     busy;
    logic                     fire;

    assign idx  = slot_req.addr[`MAIN_SLOT_AW:1];   // Wraps inside the region
    assign fire = busy && (cnt == CW'(`MAIN_WAIT));

    // Wait-state counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= fire;
            if (sel) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (fire) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Storage and read port
    always_ff @(posedge clk) begin
        if (fire) begin
            if (slot_req.we) begin
                if (slot_req.be[1]) mem[idx][15:8] <= slot_req.wdata[15:8];
                if (slot_req.be[0]) mem[idx][7:0]  <= slot_req.wdata[7:0];
                rdata <= 16'hffff;
            end else begin
                rdata <= mem[idx];
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_main_board -f project.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_main_board > sim.log 2>&1
status=$?
cat sim.log

if grep -F -q "*** TEST FAILED ***" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

/* tb_main_board.sv */
`include "main_cfg.svh"

module tb_main_board import main_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_PRELOAD  = `MAIN_SLOTS * 16;
    localparam int N_RANDOM   = 160;
    localparam int N_CAB      = 64;
    localparam int N_LATCH    = 36;
    localparam int N_UNMAPPED = 16;
    localparam int N_READBACK = `MAIN_SLOTS * 16;
    localparam int N_TOTAL    = N_PRELOAD + N_RANDOM + N_CAB + N_LATCH + N_UNMAPPED + N_READBACK;
    localparam int LIMIT_CYCLES = N_TOTAL * 40 + 500;
    // Joystick source bit for each output bit from the top bit down
    localparam int JOY_SRC [8] = '{1, 0, 3, 2, 7, 5, 4, 6};

    logic        clk = 1'b0;
    logic        rst;
    logic        req;
    bus_req_t    req_data;
    logic        ack;
    bus_rsp_t    rsp;
    cab_byte_t   joystick1, joystick2, dipsw_a, dipsw_b;
    logic [1:0]  start_button;
    logic [1:0]  coin_input;
    logic        service;
    logic [8:0]  vdump;
    logic        hstart;
    logic        irq_ack;
    logic        irq_n;
    cab_byte_t   snd_latch;
    logic        flip;

    bus_data_t   shadow [`MAIN_SLOTS][2**`MAIN_SLOT_AW];
    cab_byte_t   latch_m = 8'h00;
    cab_byte_t   ctrl_m = 8'h00;
    bus_rsp_t    exp_q [$];
    bus_rsp_t    exp_r;
    logic        ack_q = 1'b0;
    logic [31:0] rng = 32'hbb80fce4;
    int          n_issued = 0;
    int          n_checked = 0;

    always #10 clk = ~clk;

    main_board main_board_inst (.*);

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
    endtask

    function logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic int region_of(input logic [7:0] hi);
        case (hi)
            `MAIN_RGN_VRAM: return 0;
            `MAIN_RGN_OBJ:  return 1;
            `MAIN_RGN_PAL:  return 2;
            `MAIN_RGN_WRAM: return 3;
            `MAIN_RGN_IO:   return 4;
            default:        return 5;
        endcase
    endfunction

    function automatic logic [7:0] slot_code(input logic [1:0] s);
        case (s)
            2'd0:    return `MAIN_RGN_VRAM;
            2'd1:    return `MAIN_RGN_OBJ;
            2'd2:    return `MAIN_RGN_PAL;
            default: return `MAIN_RGN_WRAM;
        endcase
    endfunction

    function automatic cab_byte_t joy_order(input cab_byte_t j);
        cab_byte_t s;
        for (int k = 0; k < 8; k++) s[7-k] = j[JOY_SRC[k]];
        return s;
    endfunction

    // Reference model that also updates the shadow RAM and latch registers
    function automatic bus_rsp_t model_access(input bus_req_t r);
        bus_rsp_t   e;
        int         rg;
        cab_byte_t  lo;
        logic [1:0] ix;
        rg      = region_of(r.addr[23:16]);
        e.rdata = 16'hffff;
        e.berr  = 1'b0;
        ix      = r.addr[2:1];
        lo      = 8'hff;
        if (rg < `MAIN_SLOTS) begin
            if (!r.we) begin
                e.rdata = shadow[rg[1:0]][r.addr[`MAIN_SLOT_AW:1]];
            end else begin
                if (r.be[1]) shadow[rg[1:0]][r.addr[`MAIN_SLOT_AW:1]][15:8] = r.wdata[15:8];
                if (r.be[0]) shadow[rg[1:0]][r.addr[`MAIN_SLOT_AW:1]][7:0] = r.wdata[7:0];
            end
        end else if (rg == 4) begin
            case (r.addr[13:12])
                2'd0: lo = (ix == 2'd0) ? latch_m : (ix == 2'd1) ? ctrl_m : 8'hff;
                2'd1: begin
                    if (ix == 2'd0) lo = {2'b11, start_button, service, 1'b1, coin_input};
                    else if (ix == 2'd1) lo = joy_order(joystick1);
                    else if (ix == 2'd3) lo = joy_order(joystick2);
                end
                2'd2: lo = r.addr[1] ? dipsw_b : dipsw_a;
                default: lo = 8'hff;
            endcase
            if (!r.we) e.rdata = {8'hff, lo};
            else if (r.be[0] && r.addr[13:12] == 2'd0 && ix == 2'd0) latch_m = r.wdata[7:0];
            else if (r.be[0] && r.addr[13:12] == 2'd0 && ix == 2'd1) ctrl_m = r.wdata[7:0];
        end else begin
            e.berr = 1'b1;   // Unmapped
        end
        return e;
    endfunction

    function automatic bus_req_t make_req(input logic [7:0] hi, input logic [14:0] lo,
                                          input logic we);
        bus_req_t    r;
        logic [31:0] v;
        v       = next_rand();
        r.addr  = {hi, lo};
        r.wdata = v[15:0];
        r.we    = we;
        r.be    = v[17:16];
        return r;
    endfunction

    // Random mirror bits above the slot index
    function automatic logic [14:0] ram_lo(input logic [3:0] idx);
        logic [31:0] v;
        v = next_rand();
        return {v[4:0], 6'd0, idx};
    endfunction

    function automatic logic [14:0] io_lo(input logic [1:0] grp, input logic [1:0] idx);
        logic [31:0] v;
        v = next_rand();
        return {v[1:0], grp, v[10:2], idx};
    endfunction

    // One four-phase cycle with ack latency and hold checks
    task automatic bus_access(input bus_req_t r);
        int       lat;
        int       cyc;
        bus_rsp_t hold_rsp;
        lat = (region_of(r.addr[23:16]) < `MAIN_SLOTS) ? 4 + `MAIN_WAIT : 3;
        hold_rsp = model_access(r);
        exp_q.push_back(hold_rsp);
        n_issued++;
        req_data = r;
        req      = 1'b1;
        cyc      = 0;
        while (ack !== 1'b1 && cyc < 100) begin
            @(negedge clk);
            cyc++;
        end
        assert (ack === 1'b1) else begin
            report_fail("No ack from the board within 100 cycles");
            $fatal(1);
        end
        assert (cyc - 1 == lat) else begin
            report_fail($sformatf("Fail ack latency: got %0h expected %0h", cyc - 1, lat));
            $fatal(1);
        end
        repeat (next_rand() % 3) begin   // Slow master
            @(negedge clk);
            assert (ack === 1'b1) else begin
                report_fail("Ack dropped while req was still high");
                $fatal(1);
            end
            assert (rsp === hold_rsp) else begin
                report_fail($sformatf("Fail rsp: got %h expected %h while req was held",
                                      rsp, hold_rsp));
                $fatal(1);
            end
        end
        req = 1'b0;
        @(negedge clk);
        assert (ack === 1'b0) else begin
            report_fail("Ack did not fall after req dropped");
            $fatal(1);
        end
        @(negedge clk);   // Decoder back to idle
    endtask

    task automatic check_irq(input logic exp, input string what);
        assert (irq_n === exp) else begin
            report_fail($sformatf("Fail irq_n: got %h expected %h after %s", irq_n, exp, what));
            $fatal(1);
        end
    endtask

    // One compare per rising edge of ack
    always @(negedge clk) begin
        if (ack === 1'b1 && ack_q === 1'b0) begin
            assert (exp_q.size() > 0) else begin
                report_fail("Ack rose with no access pending");
                $fatal(1);
            end
            exp_r = exp_q.pop_front();
            assert (rsp === exp_r) else begin
                report_fail($sformatf("Fail rsp: got %h expected %h", rsp, exp_r));
                $fatal(1);
            end
            assert (snd_latch === latch_m && flip === ctrl_m[7]) else begin
                report_fail($sformatf("Fail snd_latch/flip: got %h/%h expected %h/%h",
                                      snd_latch, flip, latch_m, ctrl_m[7]));
                $fatal(1);
            end
            n_checked++;
        end
        ack_q = ack;
    end

    initial begin
        #(LIMIT_CYCLES * 20);
        report_fail("Watchdog timeout, the run took too long");
        $fatal(1);
    end

    initial begin
        logic [31:0] v;
        logic [7:0]  hi;
        logic [1:0]  grp;
        bus_req_t    r;
        rst = 1'b1;
        req = 1'b0;
        req_data = '0;
        joystick1 = 8'h00;
        joystick2 = 8'h00;
        dipsw_a = 8'h00;
        dipsw_b = 8'h00;
        start_button = 2'b00;
        coin_input = 2'b00;
        service = 1'b0;
        vdump = 9'd0;
        hstart = 1'b0;
        irq_ack = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (ack === 1'b0 && irq_n === 1'b1 && flip === 1'b0 && snd_latch === 8'h00
                && rsp === {16'hffff, 1'b0}) else begin
            report_fail("Outputs are not at their reset values");
            $fatal(1);
        end

        // Known contents in a 16-word window of every slot
        for (int s = 0; s < `MAIN_SLOTS; s++) begin
            for (int i = 0; i < 16; i++) begin
                r    = make_req(slot_code(s[1:0]), ram_lo(i[3:0]), 1'b1);
                r.be = 2'b11;
                bus_access(r);
            end
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            v = next_rand();
            bus_access(make_req(slot_code(v[1:0]), ram_lo(v[5:2]), v[6]));
        end

        // Cabinet reads with fresh inputs each round
        for (int round = 0; round < 4; round++) begin
            v = next_rand();
            joystick1 = v[7:0];
            joystick2 = v[15:8];
            dipsw_a = v[23:16];
            dipsw_b = v[31:24];
            v = next_rand();
            start_button = v[1:0];
            coin_input = v[3:2];
            service = v[4];
            for (int g = 0; g < 4; g++) begin
                for (int k = 0; k < 4; k++) begin
                    bus_access(make_req(`MAIN_RGN_IO, io_lo(g[1:0], k[1:0]), 1'b0));
                end
            end
        end

        for (int n = 0; n < N_LATCH / 3; n++) begin
            v   = next_rand();
            grp = (v[2:1] == 2'd0) ? 2'd1 : v[2:1];
            bus_access(make_req(`MAIN_RGN_IO, io_lo(2'd0, {1'b0, v[0]}), 1'b1));
            bus_access(make_req(`MAIN_RGN_IO, io_lo(2'd0, {1'b0, v[0]}), 1'b0));
            bus_access(make_req(`MAIN_RGN_IO, io_lo(grp, v[4:3]), 1'b1));
        end

        for (int n = 0; n < N_UNMAPPED; n++) begin
            do begin
                v  = next_rand();
                hi = v[7:0];
            end while (region_of(hi) != 5);
            bus_access(make_req(hi, ram_lo(v[11:8]), v[12]));
        end

        // Full readback of every window catches stray unmapped writes
        for (int s = 0; s < `MAIN_SLOTS; s++) begin
            for (int i = 0; i < 16; i++) begin
                bus_access(make_req(slot_code(s[1:0]), ram_lo(i[3:0]), 1'b0));
            end
        end

        vdump = 9'd100;
        hstart = 1'b1;
        @(negedge clk);
        hstart = 1'b0;
        @(negedge clk);
        check_irq(1'b1, "hstart on line 100");
        vdump = `MAIN_VBL_LINE;
        @(negedge clk);
        hstart = 1'b1;
        @(negedge clk);
        check_irq(1'b0, "hstart on the VBLANK line");
        repeat (5) @(negedge clk);
        check_irq(1'b0, "waiting without irq_ack");
        hstart = 1'b0;
        irq_ack = 1'b1;
        @(negedge clk);
        irq_ack = 1'b0;
        check_irq(1'b1, "irq_ack");
        hstart = 1'b1;   // New edge together with ack
        irq_ack = 1'b1;
        @(negedge clk);
        irq_ack = 1'b0;
        @(negedge clk);
        check_irq(1'b1, "irq_ack meeting an hstart edge");

        repeat (4) @(negedge clk);
        if (exp_q.size() == 0 && n_checked == n_issued) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            report_fail($sformatf("%0d of %0d responses were never compared",
                                  n_issued - n_checked, n_issued));
            $fatal(1);
        end
    end

endmodule

/* vblank_irq.sv */
`include "main_cfg.svh"

module vblank_irq (
    input  logic       clk,
    input  logic       rst,
    input  logic [8:0] vdump,
    input  logic       hstart,
    input  logic       irq_ack,
    output logic       irq_n
);

    logic hstart_q;
    logic vbl_start;

    // Line start of the first blanked line
    assign vbl_start = hstart && !hstart_q && (vdump == `MAIN_VBL_LINE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hstart_q <= 1'b0;
            irq_n    <= 1'b1;
        end else begin
            hstart_q <= hstart;
            if (irq_ack) begin
                irq_n <= 1'b1;   // Ack wins over a new request
            end else if (vbl_start) begin
                irq_n <= 1'b0;
            end
        end
    end

endmodule
